/* compile.f */
+incdir+include
logic/gpi_irq_pkg.sv
logic/gpi_reg_pkg.sv
logic/gpi_input_filter.sv
logic/gpi_pulse_classifier.sv
logic/gpi_sts_bank.sv
logic/gpi_irq_ctrl.sv
logic/gpi_irq_top.sv
bench/gpi_irq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the gpi irq testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module gpi_irq_tb \
    -f compile.f -o gpi_irq_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/gpi_irq_sim > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

/* bench/gpi_irq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gpi_settings.svh"

module gpi_irq_tb;

    localparam int CH       = `GPI_CH_NUM;
    localparam int FILT_LAT = `GPI_SYNC_STAGES + `GPI_DBS_CYCLES;     // raw edge to gpi_dbs
    localparam int EVT_TMO  = FILT_LAT + `GPI_THR_L_CYCLES + 20;

    logic                            CLK_I;
    logic                            RSTN_I;
    logic                            rd;
    gpi_reg_pkg::reg_addr_t          rd_addr;
    logic [CH-1:0][`GPI_WIDTH-1:0]   gpi;
    logic [CH-1:0][`GPI_WIDTH-1:0]   irq_mode;
    logic [CH-1:0][`GPI_WIDTH-1:0]   irq_en;
    logic [CH-1:0][`GPI_WIDTH-1:0]   gpi_dbs;
    gpi_irq_pkg::sts_word_t [CH-1:0] int_sts;
    logic                            irq;

    gpi_irq_pkg::sts_word_t          exp_sts [CH];  // expected status words
    logic [31:0]                     dbs_seen;      // gpi_dbs bits seen high in a window
    logic                            irq_seen;
    integer                          seed;
    int                              errors;
    int                              checks;

    gpi_irq_top dut (.*);

    always #20 CLK_I = ~CLK_I;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_all_sts();
        for (int c = 0; c < CH; c++) begin
            check($sformatf("int_sts[%0d]", c), int_sts[c], exp_sts[c]);
        end
    endtask

    // one falling edge per cycle, remembering what went high
    task automatic run_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK_I);
            irq_seen = irq_seen | irq;
            dbs_seen = dbs_seen | gpi_dbs;
        end
    endtask

    task automatic wait_irq(input logic val, input int tmo);
        int n = 0;
        while (irq !== val && n < tmo) begin
            run_cycles(1);
            n++;
        end
        if (irq !== val) begin
            errors++;
            $display("timeout: irq did not go to %0b within %0d cycles", val, tmo);
        end
    endtask

    // until every expected bit of the channel is set
    task automatic wait_sts(input int ch, input int tmo);
        int n = 0;
        while ((int_sts[ch] & exp_sts[ch]) !== exp_sts[ch] && n < tmo) begin
            run_cycles(1);
            n++;
        end
        if ((int_sts[ch] & exp_sts[ch]) !== exp_sts[ch]) begin
            errors++;
            $display("timeout: status of channel %0d never showed the event", ch);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_reset();
        check("irq", {31'd0, irq}, 32'h0);
        check("gpi_dbs", gpi_dbs, 32'h0);
        check_all_sts();
    endtask

    // short high pulse, then a long low which is a level and so no event
    task automatic test_pulse();
        int width;
        int high;
        width = `GPI_DBS_CYCLES + 4
                + int'($unsigned($random(seed)) % (`GPI_THR_H_CYCLES - `GPI_DBS_CYCLES - 12));
        irq_mode[1][3] = gpi_irq_pkg::MODE_PULSE;
        irq_en[1][3]   = 1'b1;
        gpi[1][3]      = 1'b1;
        run_cycles(width);
        gpi[1][3] = 1'b0;
        if (width < `GPI_THR_H_CYCLES) begin
            exp_sts[1].h_pulse[3] = 1'b1;
        end
        wait_sts(1, EVT_TMO);
        check("irq", {31'd0, irq}, 32'h1);      // rises with the status bit
        // single event, so irq holds for exactly the hold time
        high = 0;
        while (irq === 1'b1 && high < `GPI_IRQ_HOLD_CYCLES + 5) begin
            run_cycles(1);
            high++;
        end
        if (irq !== 1'b0) begin
            errors++;
            $display("timeout: irq stayed high past the hold time");
        end
        check("irq_hold", high, `GPI_IRQ_HOLD_CYCLES);
        run_cycles(EVT_TMO);
        check_all_sts();
    endtask

    task automatic test_level();
        irq_mode[2][5] = gpi_irq_pkg::MODE_LEVEL;
        irq_en[2][5]   = 1'b1;
        gpi[2][5]      = 1'b1;
        run_cycles(`GPI_THR_H_CYCLES + 20);
        exp_sts[2].h_level[5] = 1'b1;
        wait_sts(2, EVT_TMO);
        gpi[2][5] = 1'b0;
        run_cycles(`GPI_THR_L_CYCLES + 20);
        exp_sts[2].l_level[5] = 1'b1;
        wait_sts(2, EVT_TMO);
        check_all_sts();
        // short pulse in level mode adds nothing
        gpi[2][5] = 1'b1;
        run_cycles(`GPI_DBS_CYCLES + 8);
        gpi[2][5] = 1'b0;
        run_cycles(EVT_TMO);
        check_all_sts();
    endtask

    task automatic test_enable();
        irq_mode[3][0] = gpi_irq_pkg::MODE_LEVEL;
        irq_mode[3][1] = gpi_irq_pkg::MODE_PULSE;
        wait_irq(1'b0, `GPI_IRQ_HOLD_CYCLES + 10);
        irq_seen  = 1'b0;
        gpi[3][0] = 1'b1;
        run_cycles(`GPI_THR_H_CYCLES + 20);
        gpi[3][0] = 1'b0;
        gpi[3][1] = 1'b1;
        run_cycles(`GPI_DBS_CYCLES + 8);
        gpi[3][1] = 1'b0;
        run_cycles(EVT_TMO);
        check("irq_seen", {31'd0, irq_seen}, 32'h0);
        check_all_sts();
    endtask

    task automatic test_clear();
        rd      = 1'b1;
        rd_addr = gpi_reg_pkg::STS_CH1;
        run_cycles(1);
        rd = 1'b0;
        exp_sts[1] = '0;
        check_all_sts();
        rd      = 1'b1;
        rd_addr = 16'h500C;                     // no register here
        run_cycles(1);
        rd = 1'b0;
        check_all_sts();
        wait_irq(1'b0, `GPI_IRQ_HOLD_CYCLES + 5);
        check("irq", {31'd0, irq}, 32'h0);
    endtask

    task automatic test_debounce();
        int n = 0;
        irq_mode[0][7] = gpi_irq_pkg::MODE_PULSE;
        irq_en[0][7]   = 1'b1;
        dbs_seen       = '0;
        gpi[0][7]      = 1'b1;
        run_cycles(`GPI_DBS_CYCLES / 2);
        gpi[0][7] = 1'b0;
        run_cycles(FILT_LAT + `GPI_DBS_CYCLES);
        check("dbs_seen", dbs_seen, 32'h0);
        check_all_sts();
        gpi[0][7] = 1'b1;                       // stable this time
        while (gpi_dbs[0][7] !== 1'b1 && n < FILT_LAT + 1) begin
            run_cycles(1);
            n++;
        end
        if (gpi_dbs[0][7] !== 1'b1) begin
            errors++;
            $display("timeout: gpi_dbs[0][7] did not follow a stable input");
        end
        check("gpi_dbs", gpi_dbs, 32'h0000_0080);  // channel 0 bit 7 only
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        CLK_I    = 1'b0;
        RSTN_I   = 1'b0;
        rd       = 1'b0;
        rd_addr  = '0;
        gpi      = '0;
        irq_mode = '0;
        irq_en   = '0;
        seed     = 35;
        errors   = 0;
        checks   = 0;
        irq_seen = 1'b0;
        dbs_seen = '0;
        for (int c = 0; c < CH; c++) begin
            exp_sts[c] = '0;
        end
        repeat (3) @(negedge CLK_I);
        RSTN_I = 1'b1;
        run_cycles(1);
        test_reset();
        test_pulse();
        test_level();
        test_enable();
        test_clear();
        test_debounce();
        $display("gpi_irq_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/gpi_irq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gpi_settings.svh"

module gpi_irq_top (
    input  wire logic                                   CLK_I,
    input  wire logic                                   RSTN_I,
    input  wire logic                                   rd,
    input  wire gpi_reg_pkg::reg_addr_t                 rd_addr,
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] gpi,
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] irq_mode,   // per bit level or pulse
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] irq_en,
    output logic      [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] gpi_dbs,
    output gpi_irq_pkg::sts_word_t [`GPI_CH_NUM-1:0]    int_sts,
    output logic                                        irq
);

    logic [`GPI_CH_NUM-1:0] ch_event;   // any status bit set in this cycle
    logic [`GPI_CH_NUM-1:0] sts_clr;

    ////////////////////////////////////////////////////////////////////////////
    // input path

    gpi_input_filter u_filter (
        .CLK_I   (CLK_I),
        .RSTN_I  (RSTN_I),
        .gpi     (gpi),
        .gpi_dbs (gpi_dbs)
    );

    ////////////////////////////////////////////////////////////////////////////
    // classification and status

    gpi_sts_bank u_sts_bank (
        .CLK_I    (CLK_I),
        .RSTN_I   (RSTN_I),
        .gpi_dbs  (gpi_dbs),
        .irq_mode (irq_mode),
        .irq_en   (irq_en),
        .sts_clr  (sts_clr),
        .int_sts  (int_sts),
        .ch_event (ch_event)
    );

    // read decode and irq
    gpi_irq_ctrl u_ctrl (
        .CLK_I    (CLK_I),
        .RSTN_I   (RSTN_I),
        .rd       (rd),
        .rd_addr  (rd_addr),
        .ch_event (ch_event),
        .sts_clr  (sts_clr),
        .irq      (irq)
    );

endmodule

`default_nettype wire

/* logic/gpi_irq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gpi_settings.svh"

module gpi_irq_ctrl (
    input  wire logic                   CLK_I,
    input  wire logic                   RSTN_I,
    input  wire logic                   rd,         // single cycle strobe
    input  wire gpi_reg_pkg::reg_addr_t rd_addr,
    input  wire logic [`GPI_CH_NUM-1:0] ch_event,
    output logic      [`GPI_CH_NUM-1:0] sts_clr,
    output logic                        irq
);

    localparam int HOLD_W = $clog2(`GPI_IRQ_HOLD_CYCLES + 1);

    // channel to status register address
    localparam gpi_reg_pkg::sts_addr_e STS_ADDR [`GPI_CH_NUM] = '{
        gpi_reg_pkg::STS_CH0,
        gpi_reg_pkg::STS_CH1,
        gpi_reg_pkg::STS_CH2,
        gpi_reg_pkg::STS_CH3
    };

    logic [HOLD_W-1:0] hold_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // read decode

    for (genvar c = 0; c < `GPI_CH_NUM; c++) begin : g_clr
        assign sts_clr[c] = rd && (rd_addr == STS_ADDR[c]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // retriggerable irq hold

    always_ff @(posedge CLK_I) begin
        if (!RSTN_I) begin
            hold_cnt <= '0;
            irq      <= 1'b0;
        end else if (|ch_event) begin
            hold_cnt <= HOLD_W'(`GPI_IRQ_HOLD_CYCLES);     // restart on every event
            irq      <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
            irq      <= (hold_cnt > HOLD_W'(1));
        end
    end

    a_clr_onehot: assert property (@(posedge CLK_I) disable iff (!RSTN_I)
        $onehot0(sts_clr));

    a_irq_idle: assert property (@(posedge CLK_I) disable iff (!RSTN_I)
        (hold_cnt == '0) |-> !irq);

endmodule

`default_nettype wire

/* logic/gpi_sts_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gpi_settings.svh"

module gpi_sts_bank (
    input  wire logic                                   CLK_I,
    input  wire logic                                   RSTN_I,
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] gpi_dbs,
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] irq_mode,
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] irq_en,
    input  wire logic [`GPI_CH_NUM-1:0]                 sts_clr,
    output gpi_irq_pkg::sts_word_t [`GPI_CH_NUM-1:0]    int_sts,
    output logic      [`GPI_CH_NUM-1:0]                 ch_event
);

    logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] h_level_evt;
    logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] h_pulse_evt;
    logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] l_level_evt;
    logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] l_pulse_evt;
    gpi_irq_pkg::sts_word_t [`GPI_CH_NUM-1:0] sts_set;     // bits to set this cycle

    for (genvar c = 0; c < `GPI_CH_NUM; c++) begin : g_ch
        for (genvar b = 0; b < `GPI_WIDTH; b++) begin : g_bit
            // high time after a rising edge
            gpi_pulse_classifier #(
                .THRESHOLD   (`GPI_THR_H_CYCLES),
                .ACTIVE_HIGH (1'b1)
            ) u_cls_h (
                .CLK_I     (CLK_I),
                .RSTN_I    (RSTN_I),
                .sig       (gpi_dbs[c][b]),
                .mode      (gpi_irq_pkg::irq_mode_e'(irq_mode[c][b])),
                .en        (irq_en[c][b]),
                .level_evt (h_level_evt[c][b]),
                .pulse_evt (h_pulse_evt[c][b])
            );

            // low time after a falling edge
            gpi_pulse_classifier #(
                .THRESHOLD   (`GPI_THR_L_CYCLES),
                .ACTIVE_HIGH (1'b0)
            ) u_cls_l (
                .CLK_I     (CLK_I),
                .RSTN_I    (RSTN_I),
                .sig       (gpi_dbs[c][b]),
                .mode      (gpi_irq_pkg::irq_mode_e'(irq_mode[c][b])),
                .en        (irq_en[c][b]),
                .level_evt (l_level_evt[c][b]),
                .pulse_evt (l_pulse_evt[c][b])
            );
        end

        assign sts_set[c] = '{l_level: l_level_evt[c], h_level: h_level_evt[c],
                              l_pulse: l_pulse_evt[c], h_pulse: h_pulse_evt[c]};
        assign ch_event[c] = |sts_set[c];
    end

    // status bits saturate at 1, read clear takes priority
    always_ff @(posedge CLK_I) begin
        if (!RSTN_I) begin
            int_sts <= '0;
        end else begin
            for (int c = 0; c < `GPI_CH_NUM; c++) begin
                if (sts_clr[c]) begin
                    int_sts[c] <= '0;
                end else begin
                    int_sts[c] <= int_sts[c] | sts_set[c];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/gpi_pulse_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gpi_settings.svh"

module gpi_pulse_classifier #(
    parameter int unsigned THRESHOLD   = `GPI_THR_H_CYCLES,
    parameter bit          ACTIVE_HIGH = 1'b1
) (
    input  wire logic                   CLK_I,
    input  wire logic                   RSTN_I,
    input  wire logic                   sig,        // debounced bit
    input  wire gpi_irq_pkg::irq_mode_e mode,
    input  wire logic                   en,
    output logic                        level_evt,
    output logic                        pulse_evt
);

    localparam int                 CNT_W   = `GPI_CNT_W;
    localparam logic [CNT_W-1:0]   THR_CNT = CNT_W'(THRESHOLD);

    gpi_irq_pkg::cls_state_e state_q;
    logic [CNT_W-1:0]        cnt_q;
    logic                    sig_q;
    logic                    active;
    logic                    start;
    logic                    is_level;

    assign active = (sig == ACTIVE_HIGH);
    assign start  = active && (sig_q != ACTIVE_HIGH);   // edge into the active level

    always_ff @(posedge CLK_I) begin
        if (!RSTN_I) begin
            state_q <= gpi_irq_pkg::IDLE;
            cnt_q   <= '0;
            sig_q   <= 1'b0;
        end else begin
            sig_q <= sig;
            case (state_q)
                gpi_irq_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (start) begin
                        state_q <= gpi_irq_pkg::MEASURE;
                    end
                end
                gpi_irq_pkg::MEASURE: begin
                    cnt_q <= cnt_q + 1'b1;
                    // leave on threshold, or when the bit drops back
                    if (cnt_q == THR_CNT || !active) begin
                        state_q <= gpi_irq_pkg::DECIDE;
                    end
                end
                gpi_irq_pkg::DECIDE: begin
                    state_q <= gpi_irq_pkg::IDLE;
                end
                default: begin
                    state_q <= gpi_irq_pkg::IDLE;
                end
            endcase
        end
    end

    // count ran past the threshold only when the level held
    assign is_level = (cnt_q > THR_CNT);

    assign level_evt = (state_q == gpi_irq_pkg::DECIDE) && en && is_level
                       && (mode == gpi_irq_pkg::MODE_LEVEL);
    assign pulse_evt = (state_q == gpi_irq_pkg::DECIDE) && en && !is_level
                       && (mode == gpi_irq_pkg::MODE_PULSE);

    a_evt_excl: assert property (@(posedge CLK_I) disable iff (!RSTN_I)
        !(level_evt && pulse_evt));

    a_evt_single: assert property (@(posedge CLK_I) disable iff (!RSTN_I)
        (level_evt || pulse_evt) |=> !(level_evt || pulse_evt));

endmodule

`default_nettype wire

/* logic/gpi_input_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gpi_settings.svh"

module gpi_input_filter (
    input  wire logic                                   CLK_I,
    input  wire logic                                   RSTN_I,
    input  wire logic [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] gpi,
    output logic      [`GPI_CH_NUM-1:0][`GPI_WIDTH-1:0] gpi_dbs
);

    localparam int N_BITS = `GPI_CH_NUM * `GPI_WIDTH;
    localparam int DBS_W  = $clog2(`GPI_DBS_CYCLES + 1);

    logic [N_BITS-1:0] sync_q [`GPI_SYNC_STAGES];
    logic [N_BITS-1:0] sync_bits;                   // last synchronizer stage
    logic [N_BITS-1:0] dbs_q;
    logic [DBS_W-1:0]  dbs_cnt [N_BITS];            // cycles sync differs from dbs

    ////////////////////////////////////////////////////////////////////////////
    // synchronizer chain

    always_ff @(posedge CLK_I) begin
        if (!RSTN_I) begin
            for (int s = 0; s < `GPI_SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= gpi;
            for (int s = 1; s < `GPI_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign sync_bits = sync_q[`GPI_SYNC_STAGES-1];

    ////////////////////////////////////////////////////////////////////////////
    // debounce, one stability counter per bit

    always_ff @(posedge CLK_I) begin
        if (!RSTN_I) begin
            dbs_q <= '0;
            for (int b = 0; b < N_BITS; b++) begin
                dbs_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < N_BITS; b++) begin
                if (sync_bits[b] == dbs_q[b]) begin
                    dbs_cnt[b] <= '0;                   // glitch gone, start over
                end else if (dbs_cnt[b] == DBS_W'(`GPI_DBS_CYCLES - 1)) begin
                    dbs_q[b]   <= sync_bits[b];
                    dbs_cnt[b] <= '0;
                end else begin
                    dbs_cnt[b] <= dbs_cnt[b] + 1'b1;
                end
            end
        end
    end

    assign gpi_dbs = dbs_q;

endmodule

`default_nettype wire

/* logic/gpi_reg_pkg.sv */
`default_nettype none

package gpi_reg_pkg;

    // bus address as seen on rd_addr
    typedef logic [15:0] reg_addr_t;

    // status registers, one per channel, clear on read
    typedef enum reg_addr_t {
        STS_CH0 = 16'h100C,
        STS_CH1 = 16'h200C,
        STS_CH2 = 16'h300C,
        STS_CH3 = 16'h400C
    } sts_addr_e;

endpackage

`default_nettype wire

/* logic/gpi_irq_pkg.sv */
`default_nettype none

`include "gpi_settings.svh"

package gpi_irq_pkg;

    // classifier FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0,     // waiting for the active edge
        MEASURE = 2'd1,     // counting the active time
        DECIDE  = 2'd2      // event goes out in this cycle
    } cls_state_e;

    // per-bit event mode
    typedef enum logic {
        MODE_LEVEL = 1'b0,
        MODE_PULSE = 1'b1
    } irq_mode_e;

    // per-channel status word, one bit per gpi bit in each field
    typedef struct packed {
        logic [`GPI_WIDTH-1:0] l_level;     // bits 31:24 at default width
        logic [`GPI_WIDTH-1:0] h_level;
        logic [`GPI_WIDTH-1:0] l_pulse;
        logic [`GPI_WIDTH-1:0] h_pulse;     // lowest field
    } sts_word_t;

endpackage

`default_nettype wire

/* include/gpi_settings.svh */
`ifndef GPI_SETTINGS_SVH
`define GPI_SETTINGS_SVH

// channel array size
`define GPI_CH_NUM          4
`define GPI_WIDTH           8

// input filter
`define GPI_SYNC_STAGES     2
`define GPI_DBS_CYCLES      8       // stable cycles before debounced bit follows

// high or low time classification, in clock cycles
`define GPI_THR_H_CYCLES    40      // high time at or past this is a level
`define GPI_THR_L_CYCLES    60      // same for low time
`define GPI_CNT_W           16

// interrupt output
`define GPI_IRQ_HOLD_CYCLES 20      // retriggerable irq length

`endif
